/* soc_map_pkg.sv */
package soc_map_pkg;

    //////////////////////////////////////////////////////////////////////
    // peripheral word addresses
    //////////////////////////////////////////////////////////////////////

    // switch words, low half then high half of the 64 switches
    localparam logic [31:0] sw0_addr = 32'h8020_0000;
    localparam logic [31:0] sw1_addr = 32'h8020_0004;

    // eight push keys, zero-extended on read
    localparam logic [31:0] key_addr = 32'h8020_0010;

    // display value, one byte per digit pair
    localparam logic [31:0] seg_addr = 32'h8020_0020;

    // write-only
    localparam logic [31:0] led_addr = 32'h8020_0040;

    // millisecond counter, loadable
    localparam logic [31:0] cnt_addr = 32'h8020_0050;

    //////////////////////////////////////////////////////////////////////
    // data memory window
    //////////////////////////////////////////////////////////////////////

    localparam logic [31:0] dtcm_base = 32'h8010_0000;

    // returned for reads that hit nothing
    localparam logic [31:0] unmapped_word = 32'hdead_beef;

endpackage

/* perip_types_pkg.sv */
package perip_types_pkg;

    // data and address words on both bus ports
    typedef logic [31:0] word_t;

    // one write enable per byte lane, bit 0 is data[7:0]
    typedef logic [3:0] byte_mask_t;

    // segment pattern, active high, bit order gfedcba
    typedef logic [6:0] seg_pattern_t;

    //////////////////////////////////////////////////////////////////////
    // write port of the core
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       en;
        word_t      addr;
        word_t      data;
        byte_mask_t mask;
    } wr_req_t;

    //////////////////////////////////////////////////////////////////////
    // display shapes
    //////////////////////////////////////////////////////////////////////

    // one digit pair; ans is one-hot, 01 lights the low nibble
    typedef struct packed {
        logic [1:0]   ans;
        logic         dp;
        seg_pattern_t seg;
    } seg_group_t;

    // group k shows byte k of the display value
    typedef seg_group_t [3:0] seg_bus_t;

endpackage

/* data_ram.sv */
`timescale 1ns/1ns

module data_ram
    import perip_types_pkg::*;
#(
    parameter int ram_addr_width = 12
) (
    input  logic                      clk,

    // write side, one enable per byte lane
    input  byte_mask_t                we,
    input  logic [ram_addr_width-1:0] waddr,
    input  word_t                     wdata,

    // read side, registered output
    input  logic [ram_addr_width-1:0] raddr,
    output word_t                     rdata
);

    localparam int depth = 2 ** ram_addr_width;

    word_t mem [depth];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // read register, samples the array before this edge's write lands
    // so a same-word collision returns the old contents
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* ms_counter.sv */
`timescale 1ns/1ns

module ms_counter
    import perip_types_pkg::*;
#(
    parameter int clk_freq = 50_000_000
) (
    input  logic  clk,
    input  logic  rst,

    // software load
    input  logic  load,
    input  word_t load_value,

    output word_t count
);

    // cycles per millisecond
    localparam int tick_div  = clk_freq / 1000;
    localparam int pre_width = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [pre_width-1:0] prescale;
    logic                 tick;

    // last cycle of the millisecond
    assign tick = (prescale == pre_width'(tick_div - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale <= '0;
            count    <= '0;
        end else if (load) begin
            // restart the tick phase with the new value
            prescale <= '0;
            count    <= load_value;
        end else if (tick) begin
            prescale <= '0;
            count    <= count + 32'd1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

/* seg_scan.sv */
`timescale 1ns/1ns

module seg_scan
    import perip_types_pkg::*;
#(
    parameter int scan_div = 25_000
) (
    input  logic     clk,
    input  logic     rst,

    // byte k goes to group k
    input  word_t    value,

    output seg_bus_t display
);

    localparam int div_width = (scan_div > 1) ? $clog2(scan_div) : 1;

    logic [div_width-1:0] div_cnt;

    // 0 lights the low nibble, 1 the high nibble
    logic                 phase;

    //////////////////////////////////////////////////////////////////////
    // scan timing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            phase   <= 1'b0;
        end else if (div_cnt == div_width'(scan_div - 1)) begin
            div_cnt <= '0;
            phase   <= ~phase;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // hex decode
    //////////////////////////////////////////////////////////////////////

    function automatic seg_pattern_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    // all four pairs share the phase, so no extra latency on a value change
    for (genvar k = 0; k < 4; k++) begin : g_group
        logic [3:0] nibble;

        assign nibble = phase ? value[8*k+4 +: 4] : value[8*k +: 4];

        assign display[k] = '{
            ans: phase ? 2'b10 : 2'b01,
            dp:  1'b0,
            seg: hex_to_seg(nibble)
        };
    end

endmodule

/* perip_bridge.sv */
`timescale 1ns/1ns

module perip_bridge
    import soc_map_pkg::*, perip_types_pkg::*;
#(
    parameter int clk_freq       = 50_000_000,
    parameter int ram_addr_width = 12,
    parameter int scan_div       = 25_000
) (
    input  logic        clk,
    input  logic        rst,

    // core write and read ports
    input  wr_req_t     wr,
    input  word_t       raddr,
    output word_t       rdata,

    // board side
    input  logic [63:0] sw_in,
    input  logic [7:0]  key_in,
    output word_t       led,
    output seg_bus_t    display
);

    // first byte address past the data memory
    localparam word_t dtcm_end = dtcm_base + word_t'(4 * (2 ** ram_addr_width));

    word_t      led_q;
    word_t      seg_q;
    word_t      cnt_value;
    word_t      ram_rdata;

    word_t      wr_offset;
    word_t      rd_offset;
    logic       wr_in_dtcm;
    logic       rd_in_dtcm;
    byte_mask_t ram_we;
    logic       cnt_load;

    logic       rd_dtcm_q;
    word_t      perip_rdata_q;

    //////////////////////////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////////////////////////

    assign wr_in_dtcm = (wr.addr >= dtcm_base) && (wr.addr < dtcm_end);
    assign wr_offset  = wr.addr - dtcm_base;

    // mask only matters for the ram
    assign ram_we   = (wr.en && wr_in_dtcm) ? wr.mask : '0;
    assign cnt_load = wr.en && (wr.addr == cnt_addr);

    // full-word registers, switch and key addresses fall through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led_q <= '0;
            seg_q <= '0;
        end else if (wr.en) begin
            case (wr.addr)
                led_addr: led_q <= wr.data;
                seg_addr: seg_q <= wr.data;
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read path, one cycle for every target
    //////////////////////////////////////////////////////////////////////

    assign rd_in_dtcm = (raddr >= dtcm_base) && (raddr < dtcm_end);
    assign rd_offset  = raddr - dtcm_base;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_dtcm_q     <= 1'b0;
            perip_rdata_q <= '0;
        end else begin
            rd_dtcm_q <= rd_in_dtcm;
            // led is not readable, so it lands in default
            case (raddr)
                sw0_addr: perip_rdata_q <= sw_in[31:0];
                sw1_addr: perip_rdata_q <= sw_in[63:32];
                key_addr: perip_rdata_q <= {24'd0, key_in};
                seg_addr: perip_rdata_q <= seg_q;
                cnt_addr: perip_rdata_q <= cnt_value;
                default:  perip_rdata_q <= unmapped_word;
            endcase
        end
    end

    assign rdata = rd_dtcm_q ? ram_rdata : perip_rdata_q;
    assign led   = led_q;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    data_ram #(
        .ram_addr_width(ram_addr_width)
    ) dtcm_i (
        .clk  (clk),
        .we   (ram_we),
        .waddr(wr_offset[ram_addr_width+1:2]),
        .wdata(wr.data),
        .raddr(rd_offset[ram_addr_width+1:2]),
        .rdata(ram_rdata)
    );

    ms_counter #(
        .clk_freq(clk_freq)
    ) counter_i (
        .clk       (clk),
        .rst       (rst),
        .load      (cnt_load),
        .load_value(wr.data),
        .count     (cnt_value)
    );

    seg_scan #(
        .scan_div(scan_div)
    ) scan_i (
        .clk    (clk),
        .rst    (rst),
        .value  (seg_q),
        .display(display)
    );

endmodule

/* perip_top.sv */
`timescale 1ns/1ns

module perip_top
    import perip_types_pkg::*;
#(
    // 50 MHz board clock
    parameter int clk_freq       = 50_000_000,
    // 4096 words of data memory
    parameter int ram_addr_width = 12,
    // about 0.5 ms per digit at 50 MHz
    parameter int scan_div       = 25_000
) (
    input  logic        clk,
    input  logic        rst,

    // core side
    input  wr_req_t     perip_wr,
    input  word_t       perip_raddr,
    output word_t       perip_rdata,

    // board side
    input  logic [63:0] sw_in,
    input  logic [7:0]  key_in,
    output word_t       led_out,
    output seg_bus_t    seg_out
);

    perip_bridge #(
        .clk_freq      (clk_freq),
        .ram_addr_width(ram_addr_width),
        .scan_div      (scan_div)
    ) bridge_i (
        .clk    (clk),
        .rst    (rst),
        .wr     (perip_wr),
        .raddr  (perip_raddr),
        .rdata  (perip_rdata),
        .sw_in  (sw_in),
        .key_in (key_in),
        .led    (led_out),
        .display(seg_out)
    );

endmodule

/* tb_perip_top.sv */
`timescale 1ns/1ns

module tb_perip_top
    import soc_map_pkg::*, perip_types_pkg::*;
;

    localparam int          ram_words   = 64;
    localparam int unsigned tick_cycles = 8;
    localparam int          scan_cycles = 4;

    // gfedcba patterns for hex digits 0 to f
    localparam logic [6:0] seg_ref [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    typedef struct packed {
        word_t value;
        logic  loose;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst;
    wr_req_t     perip_wr;
    word_t       perip_raddr;
    word_t       perip_rdata;
    logic [63:0] sw_in;
    logic [7:0]  key_in;
    word_t       led_out;
    seg_bus_t    seg_out;

    // reference model state
    word_t       shadow [ram_words];
    word_t       led_model;
    word_t       seg_model;
    word_t       load_val;
    int unsigned load_cycle;
    int unsigned cycle = 0;
    word_t       seed = 32'h78e4586d;

    // read pipeline bookkeeping
    logic        rd_issue;
    logic        rd_pending = 1'b0;
    expect_t     exp_q [$];

    int          checks = 0;
    int          errors = 0;
    int          errors_before = 0;
    logic        seen_lo;
    logic        seen_hi;

    perip_top #(
        .clk_freq      (8000),
        .ram_addr_width(6),
        .scan_div      (scan_cycles)
    ) perip_top_i (
        .clk        (clk),
        .rst        (rst),
        .perip_wr   (perip_wr),
        .perip_raddr(perip_raddr),
        .perip_rdata(perip_rdata),
        .sw_in      (sw_in),
        .key_in     (key_in),
        .led_out    (led_out),
        .seg_out    (seg_out)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle      <= cycle + 1;
        rd_pending <= rd_issue;
    end

    //////////////////////////////////////////////////////////////////////
    // model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic word_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic in_dtcm(input word_t addr);
        return (addr >= dtcm_base) && (addr < dtcm_base + word_t'(4 * ram_words));
    endfunction

    // expected read word at the moment the read is issued
    function automatic expect_t expected_read(input word_t addr);
        expect_t e;
        e.loose = 1'b0;
        if (in_dtcm(addr)) begin
            e.value = shadow[int'((addr - dtcm_base) >> 2)];
        end else begin
            case (addr)
                sw0_addr: e.value = sw_in[31:0];
                sw1_addr: e.value = sw_in[63:32];
                key_addr: e.value = {24'd0, key_in};
                seg_addr: e.value = seg_model;
                cnt_addr: begin
                    // tick phase is only known to within one count
                    e.value = load_val + word_t'((cycle - load_cycle) / tick_cycles);
                    e.loose = 1'b1;
                end
                default:  e.value = unmapped_word;
            endcase
        end
        return e;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $finish;
    endtask

    task automatic finish_test(input string name);
        $display("test %-20s %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic write_word(input word_t addr, input word_t data, input byte_mask_t mask);
        int idx;
        perip_wr = '{en: 1'b1, addr: addr, data: data, mask: mask};
        if (in_dtcm(addr)) begin
            idx = int'((addr - dtcm_base) >> 2);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    shadow[idx][8*b +: 8] = data[8*b +: 8];
                end
            end
        end
        case (addr)
            led_addr: led_model = data;
            seg_addr: seg_model = data;
            cnt_addr: begin
                load_val   = data;
                load_cycle = cycle;
            end
            default: ;
        endcase
        @(posedge clk);
        #1;
        perip_wr.en = 1'b0;
    endtask

    task automatic issue_read(input word_t addr);
        perip_raddr = addr;
        rd_issue    = 1'b1;
        exp_q.push_back(expected_read(addr));
        @(posedge clk);
        #1;
        rd_issue = 1'b0;
    endtask

    task automatic wait_results();
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 20) begin
                abort_run("timed out waiting for read results");
            end
        end
    endtask

    task automatic sample_display(input word_t value);
        seg_group_t g;
        logic [3:0] nib;
        for (int k = 0; k < 4; k++) begin
            g = seg_out[k];
            if (g.ans == 2'b10) begin
                nib     = value[8*k+4 +: 4];
                seen_hi = 1'b1;
            end else begin
                check_value("seg_out.ans", 32'(2'b01), 32'(g.ans));
                nib     = value[8*k +: 4];
                seen_lo = seen_lo | (g.ans == 2'b01);
            end
            check_value("seg_out.dp", 32'd0, 32'(g.dp));
            check_value("seg_out.seg", 32'(seg_ref[nib]), 32'(g.seg));
        end
    endtask

    // one result per cycle in issue order
    always @(negedge clk) begin
        expect_t e;
        word_t   diff;
        if (rd_pending) begin
            if (exp_q.size() == 0) begin
                $display("read result arrived with nothing expected");
                errors++;
            end else begin
                e    = exp_q.pop_front();
                diff = perip_rdata - e.value;
                if (e.loose && (diff == 32'd1 || diff == 32'hffff_ffff)) begin
                    // one tick either way still falls in the window
                    checks++;
                end else begin
                    check_value("perip_rdata", e.value, perip_rdata);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        word_t v;
        int    n;
        int    t;
        perip_wr    = '0;
        perip_raddr = '0;
        sw_in       = '0;
        key_in      = '0;
        rd_issue    = 1'b0;
        led_model   = '0;
        seg_model   = '0;
        rst         = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        check_value("led_out", 32'd0, led_out);
        check_value("perip_rdata", 32'd0, perip_rdata);
        rst        = 1'b0;
        load_val   = '0;
        load_cycle = cycle;
        issue_read(seg_addr);
        issue_read(cnt_addr);
        wait_results();
        finish_test("reset");

        // unwritten ram words are undefined so fill them first
        for (int i = 0; i < ram_words; i++) begin
            v = dtcm_base + word_t'(4 * i);
            write_word(v, v ^ 32'h5ac3_e19b, 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            n = int'(lcg_next() % ram_words);
            v = lcg_next();
            write_word(dtcm_base + word_t'(4 * n), lcg_next(), v[3:0]);
        end
        for (int i = 0; i < ram_words; i++) begin
            issue_read(dtcm_base + word_t'(4 * i));
        end
        wait_results();
        finish_test("dtcm masking");

        sw_in  = {lcg_next(), lcg_next()};
        v      = lcg_next();
        key_in = v[7:0];
        write_word(sw0_addr, lcg_next(), 4'hf);
        write_word(sw1_addr, lcg_next(), 4'hf);
        write_word(key_addr, lcg_next(), 4'hf);
        issue_read(sw0_addr);
        issue_read(sw1_addr);
        issue_read(key_addr);
        issue_read(led_addr);
        issue_read(32'h8020_0008);
        issue_read(dtcm_base - 32'd4);
        issue_read(dtcm_base + word_t'(4 * ram_words));
        issue_read(32'h0000_0000);
        wait_results();
        finish_test("peripheral reads");

        // registers take the whole word whatever the mask
        write_word(led_addr, lcg_next(), 4'b0100);
        check_value("led_out", led_model, led_out);
        write_word(seg_addr, lcg_next(), 4'b0001);
        issue_read(seg_addr);
        wait_results();
        finish_test("led and segment");

        for (int i = 0; i < 3; i++) begin
            write_word(cnt_addr, lcg_next(), 4'hf);
            n = 20 + int'(lcg_next() % 40);
            repeat (n) @(posedge clk);
            #1;
            issue_read(cnt_addr);
            wait_results();
        end
        finish_test("counter");

        for (int i = 0; i < 2; i++) begin
            v = lcg_next();
            write_word(seg_addr, v, 4'hf);
            seen_lo = 1'b0;
            seen_hi = 1'b0;
            t       = 0;
            while (!(seen_lo && seen_hi)) begin
                @(negedge clk);
                sample_display(v);
                t++;
                if (t > 4 * scan_cycles + 4) begin
                    abort_run("display did not light both digits of a pair");
                end
            end
            @(posedge clk);
            #1;
        end
        finish_test("display");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
soc_map_pkg.sv
perip_types_pkg.sv
data_ram.sv
ms_counter.sv
seg_scan.sv
perip_bridge.sv
perip_top.sv
tb_perip_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       ?= tb_perip_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
